// ==== hw/dac_cfg.svh ====
`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

// CLK50MHZ cycles per SCK half period
// 2 gives 12.5 MHz on SCK
`define DAC_SCK_HALF 2

// Bits per DAC transfer
`define DAC_FRAME_BITS 32

// Wishbone word offsets
`define DAC_REG_CMD 0
`define DAC_REG_STATUS 1
`define DAC_REG_READBACK 2

`endif

// ==== hw/dac_pkg.sv ====
package dac_pkg;

	// Field widths of the DAC wire format
	typedef logic [11:0] dac_data_t;
	typedef logic [3:0]  dac_addr_t;
	typedef logic [3:0]  dac_cmd_t;

	// One full word on the SPI wire
	typedef logic [31:0] dac_word_t;

	// Wishbone side
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_adr_t;

	// Command as handed from bus decode to the shifter
	// Field order matches the wire, cmd first
	typedef struct packed {
		dac_cmd_t  cmd;
		dac_addr_t addr;
		dac_data_t data;
	} dac_frame_t;

	// Status register contents
	typedef struct packed {
		logic       busy;
		logic [7:0] xfer_count;
	} dac_status_t;

	// Shifter sequence
	// IDLE  waiting for a frame
	// LOAD  frame latched, waiting for an SCK fall to start
	// SHIFT chip select low, bits going out
	// DONE  one cycle, transfer finished
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		LOAD  = 2'd1,
		SHIFT = 2'd2,
		DONE  = 2'd3
	} shift_state_t;

endpackage

// ==== hw/dac_sck_gen.sv ====
`timescale 1ns/1ps
`include "dac_cfg.svh"

module dac_sck_gen (
	input  logic CLK50MHZ,
	input  logic RST,
	output logic sck_rise,
	output logic sck_fall,
	output logic sck_level
);

	// Counter wide enough for the half period
	localparam int HALF_W = $clog2(`DAC_SCK_HALF + 1);

	logic [HALF_W-1:0] half_cnt;
	logic              half_end;

	// Last cycle of the current half period
	assign half_end = (half_cnt == HALF_W'(`DAC_SCK_HALF - 1));

	// Free running divider, level flips at the end of every half
	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			half_cnt  <= '0;
			sck_level <= 1'b0;
		end else if (half_end) begin
			half_cnt  <= '0;
			sck_level <= ~sck_level;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// Strobes sit on the cycle whose edge changes the level
	// Low now and ending the half, so SCK goes high
	assign sck_rise = half_end & ~sck_level;
	// High now, so SCK goes low
	assign sck_fall = half_end & sck_level;

endmodule

// ==== hw/dac_wb_decode.sv ====
`timescale 1ns/1ps
`include "dac_cfg.svh"

module dac_wb_decode (
	input  logic                CLK50MHZ,
	input  logic                RST,
	// Wishbone classic slave
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  dac_pkg::wb_adr_t    wb_adr,
	input  dac_pkg::wb_data_t   wb_dat_w,
	output logic                wb_ack,
	// Shifter handshake
	input  logic                busy,
	output logic                frame_valid,
	output dac_pkg::dac_frame_t frame,
	// Read select for the result block
	output dac_pkg::wb_adr_t    rd_sel
);
	import dac_pkg::*;

	logic req;
	logic cmd_wr;
	logic accept;

	//////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////

	// Cycle open and not already acked
	// Ack feeds back so a held stb cannot double ack
	assign req = wb_cyc & wb_stb & ~wb_ack;

	// Write to the command register
	assign cmd_wr = wb_we & (wb_adr == wb_adr_t'(`DAC_REG_CMD));

	// Reads and other writes go at once
	// Command writes wait for the shifter to be idle
	assign accept = req & (~cmd_wr | ~busy);

	//////////////////////////////////////////////////
	// Ack and frame request
	//////////////////////////////////////////////////

	// Both register on the same edge, so frame_valid lines up
	// with the ack cycle while busy is still low
	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			wb_ack      <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			// Single cycle pulse
			wb_ack      <= accept;
			// Exactly one request per acked command write
			frame_valid <= accept & cmd_wr;
		end
	end

	//////////////////////////////////////////////////
	// Frame fields and read address
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (accept & cmd_wr) begin
			// Data 11:0, channel 15:12, command 19:16
			frame.data <= dac_data_t'(wb_dat_w[11:0]);
			frame.addr <= dac_addr_t'(wb_dat_w[15:12]);
			frame.cmd  <= dac_cmd_t'(wb_dat_w[19:16]);
		end
		// Held through the ack cycle for the read mux
		if (accept) begin
			rd_sel <= wb_adr;
		end
	end

endmodule

// ==== hw/dac_spi_shifter.sv ====
`timescale 1ns/1ps
`include "dac_cfg.svh"

module dac_spi_shifter (
	input  logic                CLK50MHZ,
	input  logic                RST,
	// Divider strobes
	input  logic                sck_rise,
	input  logic                sck_fall,
	input  logic                sck_level,
	// Request from bus decode
	input  logic                frame_valid,
	input  dac_pkg::dac_frame_t frame,
	output logic                busy,
	// DAC pins
	output logic                spi_sck,
	output logic                spi_mosi,
	output logic                dac_cs,
	output logic                dac_clr,
	input  logic                dac_out,
	// Echo to the result block
	output logic                rx_valid,
	output logic                rx_bit,
	output logic                xfer_done
);
	import dac_pkg::*;

	// Counter holds 0 up to the full frame
	localparam int CNT_W = $clog2(`DAC_FRAME_BITS + 1);
	localparam int MSB   = $bits(dac_word_t) - 1;

	shift_state_t     state;
	dac_frame_t       frame_q;
	dac_word_t        shreg;
	logic [CNT_W-1:0] bit_cnt;
	logic             cs_n;
	logic             last_bit;

	// All bits sampled
	assign last_bit = (bit_cnt == CNT_W'(`DAC_FRAME_BITS));

	//////////////////////////////////////////////////
	// Sequence and chip select
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			state   <= IDLE;
			cs_n    <= 1'b1;
			bit_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (frame_valid) begin
						state <= LOAD;
					end
				end
				// Start aligned to SCK going low
				LOAD: begin
					if (sck_fall) begin
						state   <= SHIFT;
						cs_n    <= 1'b0;
						bit_cnt <= '0;
					end
				end
				// Count sampled bits, stop on the fall after the last one
				SHIFT: begin
					if (sck_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
					if (sck_fall && last_bit) begin
						state <= DONE;
						cs_n  <= 1'b1;
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Shift register
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (state == IDLE && frame_valid) begin
			frame_q <= frame;
		end
		// Wire word: 8 zeros, cmd, addr, data, 4 zeros
		if (state == LOAD && sck_fall) begin
			shreg <= {8'h00, frame_q.cmd, frame_q.addr, frame_q.data, 4'h0};
		end else if (state == SHIFT && sck_fall) begin
			// MSB first, next bit on every falling SCK
			shreg <= {shreg[MSB-1:0], 1'b0};
		end
	end

	// Pins
	assign busy     = (state != IDLE);
	assign dac_cs   = cs_n;
	// No clock edges outside the frame
	assign spi_sck  = sck_level & ~cs_n;
	assign spi_mosi = ~cs_n & shreg[MSB];
	// Clear held while in reset
	assign dac_clr  = RST;

	// Echo bit taken on the rising SCK
	assign rx_valid  = (state == SHIFT) & sck_rise;
	assign rx_bit    = dac_out;
	assign xfer_done = (state == DONE);

endmodule

// ==== hw/dac_result.sv ====
`timescale 1ns/1ps
`include "dac_cfg.svh"

module dac_result (
	input  logic              CLK50MHZ,
	input  logic              RST,
	// From the shifter
	input  logic              rx_valid,
	input  logic              rx_bit,
	input  logic              xfer_done,
	input  logic              busy,
	// Read port
	input  dac_pkg::wb_adr_t  rd_sel,
	output dac_pkg::wb_data_t wb_dat_r
);
	import dac_pkg::*;

	dac_word_t   assemble_q;
	dac_word_t   readback_q;
	logic [7:0]  xfer_count;
	dac_status_t status;

	// Echo bits arrive MSB first
	always_ff @(posedge CLK50MHZ) begin
		if (rx_valid) begin
			assemble_q <= {assemble_q[$bits(dac_word_t)-2:0], rx_bit};
		end
	end

	//////////////////////////////////////////////////
	// Readback and transfer count
	//////////////////////////////////////////////////

	// Both visible on the cycle after xfer_done
	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			readback_q <= '0;
			xfer_count <= '0;
		end else if (xfer_done) begin
			readback_q <= assemble_q;
			// Wraps at 256
			xfer_count <= xfer_count + 1'b1;
		end
	end

	assign status.busy       = busy;
	assign status.xfer_count = xfer_count;

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	always_comb begin
		wb_dat_r = '0;
		if (rd_sel == wb_adr_t'(`DAC_REG_STATUS)) begin
			// Busy in bit 0, count in 15:8
			wb_dat_r[0]    = status.busy;
			wb_dat_r[15:8] = status.xfer_count;
		end else if (rd_sel == wb_adr_t'(`DAC_REG_READBACK)) begin
			wb_dat_r = wb_data_t'(readback_q);
		end
		// Command register and unmapped offsets read zero
	end

endmodule

// ==== hw/dac_spi_top.sv ====
`timescale 1ns/1ps

module dac_spi_top (
	input  logic              CLK50MHZ,
	input  logic              RST,
	// Wishbone classic slave
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  dac_pkg::wb_adr_t  wb_adr,
	input  dac_pkg::wb_data_t wb_dat_w,
	output dac_pkg::wb_data_t wb_dat_r,
	output logic              wb_ack,
	// DAC pins
	output logic              spi_sck,
	output logic              spi_mosi,
	output logic              dac_cs,
	output logic              dac_clr,
	input  logic              dac_out
);
	import dac_pkg::*;

	// Divider strobes
	logic       sck_rise;
	logic       sck_fall;
	logic       sck_level;
	// Decode to shifter
	logic       busy;
	logic       frame_valid;
	dac_frame_t frame;
	// Shifter to result
	logic       rx_valid;
	logic       rx_bit;
	logic       xfer_done;
	// Decode to result
	wb_adr_t    rd_sel;

	dac_sck_gen dac_sck_gen_inst (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.sck_rise(sck_rise), .sck_fall(sck_fall), .sck_level(sck_level)
	);

	dac_wb_decode dac_wb_decode_inst (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack),
		.busy(busy), .frame_valid(frame_valid), .frame(frame), .rd_sel(rd_sel)
	);

	dac_spi_shifter dac_spi_shifter_inst (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.sck_rise(sck_rise), .sck_fall(sck_fall), .sck_level(sck_level),
		.frame_valid(frame_valid), .frame(frame), .busy(busy),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi), .dac_cs(dac_cs), .dac_clr(dac_clr),
		.dac_out(dac_out),
		.rx_valid(rx_valid), .rx_bit(rx_bit), .xfer_done(xfer_done)
	);

	dac_result dac_result_inst (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.rx_valid(rx_valid), .rx_bit(rx_bit), .xfer_done(xfer_done),
		.busy(busy), .rd_sel(rd_sel), .wb_dat_r(wb_dat_r)
	);

endmodule

// ==== verification/dac_model.sv ====
`timescale 1ns/1ps

module dac_model (
	input  logic spi_sck,
	input  logic spi_mosi,
	input  logic dac_cs,
	output logic dac_out
);
	import dac_pkg::*;

	localparam int W = $bits(dac_word_t);

	// Words taken off MOSI, oldest first
	dac_word_t rx_words[$];
	dac_word_t rx_shift;
	// Previous word, sent back during the next frame
	dac_word_t echo_word;
	int        bit_idx;

	initial begin
		dac_out   = 1'b0;
		rx_shift  = '0;
		echo_word = '0;
		bit_idx   = 0;
	end

	// Frame start, echo MSB ready before the first SCK rise
	always @(negedge dac_cs) begin
		bit_idx = 0;
		dac_out = echo_word[W-1];
	end

	// MOSI taken on SCK rise
	// Short settle so a zero width pulse is not seen as an edge
	always @(posedge spi_sck) begin
		#1;
		if (spi_sck === 1'b1 && dac_cs === 1'b0) begin
			rx_shift = {rx_shift[W-2:0], spi_mosi};
			bit_idx  = bit_idx + 1;
		end
	end

	// Next echo bit after SCK fall
	always @(negedge spi_sck) begin
		#1;
		if (spi_sck === 1'b0 && dac_cs === 1'b0 && bit_idx < W) begin
			dac_out = echo_word[W-1-bit_idx];
		end
	end

	// Frame end, only complete words count
	always @(posedge dac_cs) begin
		if (bit_idx == W) begin
			rx_words.push_back(rx_shift);
			echo_word = rx_shift;
		end
		bit_idx = 0;
		dac_out = 1'b0;
	end

endmodule

// ==== verification/dac_spi_tb.sv ====
`timescale 1ns/1ps
`include "dac_cfg.svh"

module dac_spi_tb;
	import dac_pkg::*;

	// One SCK period in ns
	localparam int SCK_NS = 2 * `DAC_SCK_HALF * 20;
	// 40 frames of 32 SCK periods, doubled for bus and polling overhead
	localparam int WATCHDOG_NS = 40 * 32 * SCK_NS * 2 + 20000;

	logic        CLK50MHZ;
	logic        RST;
	logic        wb_cyc, wb_stb, wb_we, wb_ack;
	wb_adr_t     wb_adr;
	wb_data_t    wb_dat_w, wb_dat_r;
	logic        spi_sck, spi_mosi, dac_cs, dac_clr, dac_out;

	dac_word_t   exp_words[$];
	dac_word_t   last_sent;
	logic [31:0] lcg_state;
	int          xfers;
	string       test_name;

	dac_spi_top dac_spi_top_inst (.*);
	dac_model   dac_model_inst (.*);

	always #10 CLK50MHZ = ~CLK50MHZ;

	//////////////////////////////////////////////////
	// Reference and random source
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Wire word: 8 zeros, command, channel, code, 4 zeros
	function automatic dac_word_t dac_word_ref(input dac_cmd_t cmd, input dac_addr_t addr,
			input dac_data_t data);
		return {8'h00, cmd, addr, data, 4'h0};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input dac_word_t exp, input dac_word_t act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED %s expected %08h actual %08h", name, exp, act));
	endtask

	task automatic check_status(input string name, input dac_status_t exp,
			input dac_status_t act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED %s expected busy %0b count %0d actual busy %0b count %0d",
				name, exp.busy, exp.xfer_count, act.busy, act.xfer_count));
	endtask

	task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED %s expected %08h actual %08h", name, exp, act));
	endtask

	task automatic check_pin(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
	endtask

	//////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////

	// Held until ack, ack seen mid cycle
	task automatic bus_access(input logic we, input wb_adr_t adr, input wb_data_t dat,
			output wb_data_t rdat);
		@(posedge CLK50MHZ);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		do begin
			@(negedge CLK50MHZ);
		end while (wb_ack !== 1'b1);
		rdat = wb_dat_r;
		@(posedge CLK50MHZ);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	// Busy in bit 0, count in 15:8
	task automatic read_status(output dac_status_t st);
		wb_data_t d;
		bus_access(1'b0, wb_adr_t'(`DAC_REG_STATUS), '0, d);
		st.busy       = d[0];
		st.xfer_count = d[15:8];
	endtask

	task automatic send_command(input wb_data_t w);
		wb_data_t unused;
		last_sent = dac_word_ref(dac_cmd_t'(w[19:16]), dac_addr_t'(w[15:12]),
			dac_data_t'(w[11:0]));
		exp_words.push_back(last_sent);
		xfers++;
		bus_access(1'b1, wb_adr_t'(`DAC_REG_CMD), w, unused);
	endtask

	// Poll until idle, then count and echo
	task automatic finish_transfer(input dac_word_t echo_exp);
		dac_status_t st;
		wb_data_t    rb;
		do begin
			read_status(st);
		end while (st.busy);
		check_status(test_name, dac_status_t'{busy: 1'b0, xfer_count: 8'(xfers)}, st);
		bus_access(1'b0, wb_adr_t'(`DAC_REG_READBACK), '0, rb);
		check_word({test_name, " readback"}, echo_exp, dac_word_t'(rb));
	endtask

	task automatic run_one(input wb_data_t w);
		dac_word_t echo;
		echo = last_sent;
		send_command(w);
		finish_transfer(echo);
	endtask

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	// Model words against the reference, in order
	initial begin : compare_words
		dac_word_t got;
		forever begin
			@(negedge CLK50MHZ);
			if (dac_model_inst.rx_words.size() > 0) begin
				got = dac_model_inst.rx_words.pop_front();
				if (exp_words.size() == 0)
					abort_run("DAC model received a word that no command asked for");
				else
					check_word(test_name, exp_words.pop_front(), got);
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		abort_run("watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : main_flow
		dac_status_t st;
		wb_data_t    rd;
		dac_word_t   pair_first;
		CLK50MHZ  = 1'b0;
		RST       = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		last_sent = '0;
		lcg_state = 32'h1ac6;
		xfers     = 0;

		// Reset over 5 rising edges, clear low meanwhile
		test_name = "reset";
		repeat (4) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		check_pin("reset dac_clr", 1'b0, dac_clr);
		@(posedge CLK50MHZ);
		RST <= 1'b1;
		@(negedge CLK50MHZ);
		check_pin("idle dac_clr", 1'b1, dac_clr);
		check_pin("idle dac_cs", 1'b1, dac_cs);
		check_pin("idle spi_sck", 1'b0, spi_sck);
		read_status(st);
		check_status("idle status", dac_status_t'{busy: 1'b0, xfer_count: 8'd0}, st);

		// Single command, echo of the reset word is zero
		test_name = "single";
		run_one(32'h0003_4abc);

		// Second write stalls for the first frame
		test_name = "back_to_back";
		send_command(32'h0002_1555);
		pair_first = last_sent;
		send_command(32'h0001_faa0);
		// First word already at the DAC when the second ack came
		if (exp_words.size() != 1)
			abort_run("second command was acked before the first frame finished");
		finish_transfer(pair_first);

		test_name = "random";
		repeat (30) begin
			lcg_state = lcg_next(lcg_state);
			run_one(lcg_state);
		end

		// Unmapped offsets, and the command register, read zero
		test_name = "unmapped";
		for (int a = 0; a < 16; a++) begin
			if (a != `DAC_REG_STATUS && a != `DAC_REG_READBACK) begin
				bus_access(1'b0, wb_adr_t'(a), '0, rd);
				check_data("unmapped read", '0, rd);
			end
		end
		for (int a = 0; a < 16; a++) begin
			if (a != `DAC_REG_CMD && a != `DAC_REG_STATUS && a != `DAC_REG_READBACK) begin
				lcg_state = lcg_next(lcg_state);
				bus_access(1'b1, wb_adr_t'(a), lcg_state, rd);
			end
		end
		// Long enough for a stray frame to finish
		#((`DAC_FRAME_BITS + 2) * SCK_NS);
		read_status(st);
		check_status("unmapped write", dac_status_t'{busy: 1'b0, xfer_count: 8'(xfers)}, st);

		test_name = "drain";
		repeat (4) @(negedge CLK50MHZ);
		if (exp_words.size() == 0 && dac_model_inst.rx_words.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			abort_run("words left unmatched between the reference and the DAC model");
		end
	end

endmodule

// ==== dac_spi_top.f ====
+incdir+hw
hw/dac_pkg.sv
hw/dac_sck_gen.sv
hw/dac_wb_decode.sv
hw/dac_spi_shifter.sv
hw/dac_result.sv
hw/dac_spi_top.sv
verification/dac_model.sv
verification/dac_spi_tb.sv

// ==== Makefile ====
# Verilator build and run of the DAC SPI testbench

SRCS := $(shell grep -v '^+' dac_spi_top.f) hw/dac_cfg.svh

.PHONY: run clean

# Pass only when the simulator output holds the pass line
run: obj_dir/Vdac_spi_tb
	@out="$$(./obj_dir/Vdac_spi_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

# Rebuilt only when a source or the file list changes
obj_dir/Vdac_spi_tb: dac_spi_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module dac_spi_tb -f dac_spi_top.f

clean:
	rm -rf obj_dir
